// ==== logic/key_pkg.sv ====
// Key format package: widths, byte count and load FSM states for the key loader
package key_pkg;

    // Configuration stream geometry
    localparam int KEY_BYTES  = 20;                 // Bytes per configuration stream
    localparam int BYTE_W     = 8;
    localparam int RAW_W      = BYTE_W * KEY_BYTES; // 160 raw bits
    localparam int CNT_W      = 5;                  // Enough for index 0..19

    // Derived key words
    localparam int KEY_W      = 64;                 // Cipher key
    localparam int RNG_W      = 16;                 // Encrypted address range
    localparam int SUM_W      = 12;                 // Running byte sum

    // Bit-selection network is built from 16-bit groups
    localparam int GRP_W      = 16;
    localparam int KEY_GROUPS = RAW_W / GRP_W;      // 10 groups

    // One byte as written by the host
    typedef logic [BYTE_W-1:0] key_byte_t;

    // Whole stream, first byte at the bottom once loaded
    typedef logic [RAW_W-1:0] raw_t;

    // Key handed to the decryption core
    typedef logic [KEY_W-1:0] key_t;

    // Upper bound of the encrypted address window
    typedef logic [RNG_W-1:0] addr_rng_t;

    // Sum of all bytes, zero-extended adds
    typedef logic [SUM_W-1:0] key_sum_t;

    // Byte index inside the stream
    typedef logic [CNT_W-1:0] byte_cnt_t;

    // Load sequencing
    typedef enum logic [1:0] {
        IDLE = 2'd0,                                // Nothing loaded yet
        LOAD = 2'd1,                                // Taking stream bytes
        DONE = 2'd2                                 // Key complete and valid
    } load_state_t;

endpackage

// ==== logic/bus_pkg.sv ====
// Bus package: Wishbone classic request and response structs plus register map
package bus_pkg;

    localparam int WB_ADR_W = 8;
    localparam int WB_DAT_W = 32;

    typedef logic [WB_ADR_W-1:0] wb_adr_t;             // Byte offset into the map
    typedef logic [WB_DAT_W-1:0] wb_dat_t;

    // Master to slave, held stable until ack
    typedef struct packed {
        logic    cyc;                                  // Bus cycle in progress
        logic    stb;                                  // Transfer strobe
        logic    we;                                   // High for write
        wb_adr_t adr;
        wb_dat_t dat_w;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic    ack;                                  // One cycle per transfer
        wb_dat_t dat_r;                                // Valid with ack
    } wb_rsp_t;

    // Register offsets
    localparam wb_adr_t REG_CTRL   = 8'h00;            // Bit 0 starts a load
    localparam wb_adr_t REG_DATA   = 8'h04;            // Bits 7:0 carry a stream byte
    localparam wb_adr_t REG_STATUS = 8'h08;            // Busy, done, sum
    localparam wb_adr_t REG_KEY_LO = 8'h0C;            // Key 31:0
    localparam wb_adr_t REG_KEY_HI = 8'h10;            // Key 63:32
    localparam wb_adr_t REG_RANGE  = 8'h14;            // Range in 15:0

    // Field positions
    localparam int CTRL_START_BIT = 0;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;
    localparam int STAT_SUM_LSB   = 16;                // Sum sits in 27:16

endpackage

// ==== logic/key_load_fsm.sv ====
// Key load FSM: sequences start, byte acceptance and completion of a key stream
`timescale 1ns/1ps

module key_load_fsm
    import key_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start_pulse,                       // CTRL write with start bit
    input  logic data_wr,                           // DATA write strobe
    input  logic last,                              // Counter sits on final byte
    output logic clear,                             // Wipe raw, sum and count
    output logic shift_en,                          // Take data byte this cycle
    output logic busy,
    output logic key_valid
);

    load_state_t state;
    load_state_t state_next;

    // Start always wins, even mid-load
    assign clear    = start_pulse;
    assign shift_en = data_wr && (state == LOAD);   // Strays outside LOAD dropped

    always_comb begin
        state_next = state;
        if (start_pulse) begin
            state_next = LOAD;                      // Restart from any state
        end else begin
            case (state)
                IDLE: state_next = IDLE;            // Wait for start
                LOAD: begin
                    if (shift_en && last) begin
                        state_next = DONE;          // 20th byte taken
                    end
                end
                DONE: state_next = DONE;            // Hold key until next start
                default: state_next = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Flags come off flops, one cycle behind the state edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            key_valid <= 1'b0;
        end else begin
            busy      <= (state == LOAD);           // High from the cycle after entry
            key_valid <= (state == DONE);           // Drops once a restart is seen
        end
    end

endmodule

// ==== logic/byte_counter.sv ====
// Byte counter: counts accepted stream bytes and flags the final one
`timescale 1ns/1ps

module byte_counter
    import key_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic clear,                             // From start
    input  logic shift_en,                          // One per accepted byte
    output logic last                               // Next byte completes the stream
);

    // Index of the byte about to be taken
    byte_cnt_t cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (clear) begin
            cnt <= '0;                              // New stream
        end else if (shift_en) begin
            cnt <= cnt + byte_cnt_t'(1);
        end
    end

    // FSM only ever sees this compare
    assign last = (cnt == byte_cnt_t'(KEY_BYTES - 1));

endmodule

// ==== logic/key_shift.sv ====
// Key shift block: gathers stream bytes, keeps the byte sum and selects key and range bits
`timescale 1ns/1ps

module key_shift
    import key_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      clear,                        // Start of a new stream
    input  logic      shift_en,                     // Byte accepted
    input  key_byte_t data_byte,
    output key_t      key,
    output addr_rng_t addr_rng,
    output key_sum_t  sum
);

    raw_t raw;                                      // Stream bytes, oldest at 7:0
    raw_t cfg;                                      // Reordered configuration word

    // Raw bit feeding the low word of each 16-bit config group
    // Group 0 is cfg[15:0]; upper key groups swap pairwise
    function automatic int grp_base(input int grp);
        case (grp)
            0:       return 128;
            1:       return 144;
            2:       return 96;
            3:       return 112;
            4:       return 80;
            5:       return 64;
            6:       return 48;
            7:       return 32;
            8:       return 16;
            default: return 0;                      // Group 9, range word
        endcase
    endfunction

    // Raw position for bit pos of a group starting at base
    // Bits arrive reversed, two low bits borrowed from the group below
    function automatic int src_bit(input int base, input int pos);
        if (pos >= 10) begin
            return base + 25 - pos;                 // Six bits from base+10 up
        end else if (pos >= 2) begin
            return base + 9 - pos;                  // Low byte of the group
        end else begin
            return (base + RAW_W - 7 - pos) % RAW_W; // Wraps for group 9
        end
    endfunction

    function automatic raw_t select_cfg(input raw_t src);
        raw_t res;
        int   base;
        res = '0;
        for (int grp = 0; grp < KEY_GROUPS; grp++) begin
            base = grp_base(grp);
            for (int pos = 0; pos < GRP_W; pos++) begin
                res[grp*GRP_W + pos] = src[src_bit(base, pos)];
            end
        end
        return res;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raw <= '0;
            sum <= '0;
        end else if (clear) begin
            raw <= '0;                              // Discard partial stream
            sum <= '0;
        end else if (shift_en) begin
            raw <= {data_byte, raw[RAW_W-1:BYTE_W]}; // New byte on top, rest slides down
            sum <= sum + key_sum_t'(data_byte);     // Zero-extended add
        end
    end

    // Pure wiring once unrolled
    always_comb begin
        cfg = select_cfg(raw);
    end

    assign key      = cfg[KEY_W-1:0];               // Low four groups
    assign addr_rng = cfg[RAW_W-1 -: RNG_W];        // Top group

endmodule

// ==== logic/key_regs.sv ====
// Key register block: Wishbone classic slave with command pulses and readback mux
`timescale 1ns/1ps

module key_regs
    import key_pkg::*;
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  wb_req_t   wb_req,
    output wb_rsp_t   wb_rsp,
    output logic      start_pulse,                  // Aligned with ack
    output logic      data_wr,                      // Aligned with ack
    output key_byte_t data_byte,
    input  logic      busy,
    input  logic      key_valid,
    input  key_sum_t  sum,
    input  key_t      key,
    input  addr_rng_t addr_rng
);

    logic    ack_q;
    wb_dat_t dat_r_q;
    logic    wb_hit;                                // New transfer seen this cycle
    wb_dat_t rd_data;

    // Ack high blocks a second hit while stb is still up
    assign wb_hit = wb_req.cyc && wb_req.stb && !ack_q;

    // Readback mux
    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            REG_STATUS: begin
                rd_data[STAT_BUSY_BIT]             = busy;
                rd_data[STAT_DONE_BIT]             = key_valid;
                rd_data[STAT_SUM_LSB +: SUM_W]     = sum;
            end
            REG_KEY_LO: rd_data = key[WB_DAT_W-1:0];
            REG_KEY_HI: rd_data = key[KEY_W-1:WB_DAT_W];
            REG_RANGE:  rd_data[RNG_W-1:0] = addr_rng;
            default:    rd_data = '0;               // CTRL, DATA and holes read zero
        endcase
    end

    // Handshake and command strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q       <= 1'b0;
            start_pulse <= 1'b0;
            data_wr     <= 1'b0;
        end else begin
            ack_q       <= wb_hit;                  // Single-cycle ack
            start_pulse <= wb_hit && wb_req.we && (wb_req.adr == REG_CTRL)
                           && wb_req.dat_w[CTRL_START_BIT];
            data_wr     <= wb_hit && wb_req.we && (wb_req.adr == REG_DATA);
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (wb_hit) begin
            data_byte <= wb_req.dat_w[BYTE_W-1:0];
            dat_r_q   <= wb_req.we ? '0 : rd_data;  // Sampled with the request
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_r_q;

endmodule

// ==== logic/key_loader_top.sv ====
// Key loader top: Wishbone slave, load FSM, byte counter and shift block
`timescale 1ns/1ps

module key_loader_top
    import key_pkg::*;
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  wb_req_t   wb_req,                       // From host CPU
    output wb_rsp_t   wb_rsp,
    output key_t      key,                          // To decryption core
    output addr_rng_t addr_rng,
    output logic      key_valid
);

    logic      start_pulse;
    logic      data_wr;
    key_byte_t data_byte;
    logic      clear;
    logic      shift_en;
    logic      last;
    logic      busy;
    key_sum_t  sum;

    key_regs i_key_regs (
        .clk         (clk),
        .rst         (rst),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .start_pulse (start_pulse),
        .data_wr     (data_wr),
        .data_byte   (data_byte),
        .busy        (busy),
        .key_valid   (key_valid),
        .sum         (sum),
        .key         (key),
        .addr_rng    (addr_rng)
    );

    key_load_fsm i_key_load_fsm (
        .clk         (clk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .data_wr     (data_wr),
        .last        (last),
        .clear       (clear),
        .shift_en    (shift_en),
        .busy        (busy),
        .key_valid   (key_valid)
    );

    byte_counter i_byte_counter (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .shift_en (shift_en),
        .last     (last)
    );

    key_shift i_key_shift (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .shift_en  (shift_en),
        .data_byte (data_byte),
        .key       (key),
        .addr_rng  (addr_rng),
        .sum       (sum)
    );

endmodule

// ==== bench/key_model.svh ====
// Key loader reference model: stream capture, byte sum, load state and key bit selection

raw_t        ref_raw;                               // Stream as the host wrote it
key_sum_t    ref_sum;
load_state_t ref_state;
int          ref_cnt;                               // Bytes taken in this stream

// Raw 16-bit group feeding each config group, config group 0 first
localparam int SRC_GRP [0:KEY_GROUPS-1] = '{8, 9, 6, 7, 5, 4, 3, 2, 1, 0};

function automatic logic [15:0] reverse16(input logic [15:0] w);
    logic [15:0] r;
    for (int i = 0; i < 16; i++) begin
        r[i] = w[15-i];
    end
    return r;
endfunction

// Each raw group is bit reversed and rotated right by six
// The two bottom bits come from the reversed group below instead
function automatic raw_t select_bits();
    raw_t        cfg;
    logic [15:0] cur;
    logic [15:0] below;
    int          s;
    cfg = '0;
    for (int g = 0; g < KEY_GROUPS; g++) begin
        s     = SRC_GRP[g];
        cur   = reverse16(ref_raw[s*GRP_W +: GRP_W]);
        below = reverse16(ref_raw[((s + KEY_GROUPS - 1) % KEY_GROUPS)*GRP_W +: GRP_W]);
        cfg[g*GRP_W +: GRP_W] = {cur[5:0], cur[15:8], below[7:6]};
    end
    return cfg;
endfunction

function automatic key_t expected_key();
    raw_t cfg;
    cfg = select_bits();
    return cfg[KEY_W-1:0];                          // Low four groups
endfunction

function automatic addr_rng_t expected_range();
    raw_t cfg;
    cfg = select_bits();
    return cfg[RAW_W-1 -: RNG_W];                   // Top group
endfunction

task automatic reset_model();
    ref_raw   = '0;
    ref_sum   = '0;
    ref_state = IDLE;
    ref_cnt   = 0;
endtask

// Register map behavior for one host write
task automatic apply_write(input wb_adr_t adr, input wb_dat_t dat);
    if (adr == REG_CTRL && dat[0]) begin
        ref_raw   = '0;                             // Start or restart
        ref_sum   = '0;
        ref_cnt   = 0;
        ref_state = LOAD;
    end else if (adr == REG_DATA && ref_state == LOAD) begin
        ref_raw = {dat[7:0], ref_raw[RAW_W-1:8]};   // Newest byte on top
        ref_sum = ref_sum + key_sum_t'(dat[7:0]);
        ref_cnt = ref_cnt + 1;
        if (ref_cnt == KEY_BYTES) begin
            ref_state = DONE;
        end
    end
endtask

// ==== bench/tb_key_loader.sv ====
// Key loader testbench: LFSR-driven Wishbone host checked against a reference model
`timescale 1ns/1ps

module tb_key_loader
    import key_pkg::*;
    import bus_pkg::*;
();

    localparam int          PLAN_TXNS   = 400;      // Upper bound on bus transfers
    localparam int          CYCLE_LIMIT = 40 * PLAN_TXNS;
    localparam logic [31:0] SEED        = 32'ha545_f14a;

    // Offsets whose writes must leave the key alone outside LOAD
    localparam wb_adr_t STRAY_ADR [0:7] = '{REG_DATA, REG_DATA, REG_STATUS, REG_KEY_LO,
                                            REG_KEY_HI, REG_RANGE, 8'h18, 8'h7C};

    logic        clk;
    logic        rst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    key_t        key;
    addr_rng_t   addr_rng;
    logic        key_valid;
    logic [31:0] lfsr;
    int          cycle_cnt;

    `include "key_model.svh"

    key_loader_top i_key_loader_top (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .key       (key),
        .addr_rng  (addr_rng),
        .key_valid (key_valid)
    );

    always #20 clk = ~clk;                          // 40 ns period

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("** Error at %0t ns: %s mismatch, got %0h expected %0h", $time, what, got, exp);
        $display("TB FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_key(input key_t act, input key_t exp, input string what);
        if (act !== exp) begin
            report_mismatch(what, 64'(act), 64'(exp));
        end
    endtask

    task automatic check_range(input addr_rng_t act, input addr_rng_t exp, input string what);
        if (act !== exp) begin
            report_mismatch(what, 64'(act), 64'(exp));
        end
    endtask

    task automatic check_sum(input key_sum_t act, input key_sum_t exp, input string what);
        if (act !== exp) begin
            report_mismatch(what, 64'(act), 64'(exp));
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            report_mismatch(what, 64'(act), 64'(exp));
        end
    endtask

    // Classic cycle with the request held until ack
    task automatic wb_transfer(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                               output wb_dat_t rdata);
        int waits;
        @(negedge clk);
        check_flag(wb_rsp.ack, 1'b0, "ack low between transfers"); // Ack lasts one cycle
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = dat;
        waits        = 0;
        @(negedge clk);
        while (wb_rsp.ack !== 1'b1) begin
            @(negedge clk);
            waits = waits + 1;
        end
        rdata  = wb_rsp.dat_r;                      // Valid with ack
        wb_req = '0;
        check_flag(waits == 0, 1'b1, "ack one cycle after request");
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
        wb_dat_t unused;
        wb_transfer(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_dat_t data);
        wb_transfer(1'b0, adr, '0, data);
    endtask

    task automatic host_write(input wb_adr_t adr, input wb_dat_t dat);
        wb_write(adr, dat);
        apply_write(adr, dat);
    endtask

    task automatic idle_gap();
        repeat (rand_bits(2)) @(negedge clk);       // Zero to three idle cycles
    endtask

    // Start then n random bytes with flags settled two cycles after the last ack
    task automatic load_stream(input int n, input logic gaps);
        if (gaps) idle_gap();
        host_write(REG_CTRL, 32'h1);
        for (int i = 0; i < n; i++) begin
            if (gaps) idle_gap();
            host_write(REG_DATA, wb_dat_t'(rand_bits(8)));
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic stray_writes(input int n);
        wb_adr_t adr;
        for (int i = 0; i < n; i++) begin
            adr = (i == 0) ? REG_DATA : STRAY_ADR[rand_bits(3)]; // At least one DATA write
            host_write(adr, rand_bits(32));
        end
    endtask

    // Readback registers and output ports against the model
    task automatic check_outputs();
        wb_dat_t lo;
        wb_dat_t hi;
        wb_dat_t rng;
        wb_dat_t st;
        wb_read(REG_KEY_LO, lo);
        wb_read(REG_KEY_HI, hi);
        wb_read(REG_RANGE, rng);
        wb_read(REG_STATUS, st);
        check_key({hi, lo}, expected_key(), "KEY readback");
        check_range(rng[RNG_W-1:0], expected_range(), "RANGE readback");
        check_sum(st[STAT_SUM_LSB +: SUM_W], ref_sum, "STATUS sum");
        check_flag(st[STAT_BUSY_BIT], ref_state == LOAD, "STATUS busy");
        check_flag(st[STAT_DONE_BIT], ref_state == DONE, "STATUS done");
        check_key(key, expected_key(), "key port");
        check_range(addr_rng, expected_range(), "addr_rng port");
        check_flag(key_valid, ref_state == DONE, "key_valid port");
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        wb_dat_t st;
        wb_dat_t rd;
        clk    = 1'b0;
        rst    = 1'b1;
        wb_req = '0;
        lfsr   = SEED;
        reset_model();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check_flag(key_valid, 1'b0, "key_valid after reset");
        wb_read(REG_STATUS, st);
        check_flag(st[STAT_BUSY_BIT], 1'b0, "busy after reset");
        check_flag(st[STAT_DONE_BIT], 1'b0, "done after reset");
        check_sum(st[STAT_SUM_LSB +: SUM_W], '0, "sum after reset");
        stray_writes(4);                            // Still IDLE
        check_outputs();
        load_stream(KEY_BYTES, 1'b0);
        check_outputs();
        stray_writes(4);                            // Now DONE
        check_outputs();
        load_stream(KEY_BYTES / 2, 1'b0);           // Partial stream before a restart
        check_outputs();
        load_stream(KEY_BYTES, 1'b0);
        check_outputs();
        for (int n = 0; n < 10; n++) begin
            load_stream(KEY_BYTES, 1'b1);
            check_outputs();
            if (rand_bits(1) != '0) begin
                stray_writes(1);
                check_outputs();
            end
            wb_read(wb_adr_t'(8'h18 + 4 * rand_bits(4)), rd); // Map hole
            check_flag(rd == '0, 1'b1, "undefined offset reads zero");
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+bench
logic/key_pkg.sv
logic/bus_pkg.sv
logic/key_load_fsm.sv
logic/byte_counter.sv
logic/key_shift.sv
logic/key_regs.sv
logic/key_loader_top.sv
bench/tb_key_loader.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat tb.f))

obj_dir/Vtb_key_loader: tb.f $(SRCS) bench/key_model.svh
	verilator --binary --timing -j 0 --top-module tb_key_loader -f tb.f -o Vtb_key_loader

run: obj_dir/Vtb_key_loader
	./obj_dir/Vtb_key_loader

clean:
	rm -rf obj_dir

.PHONY: run clean
